// File: rtl/upsp_ac_pkg.sv
package upsp_ac_pkg;

	// Stream word
	localparam int data_width = 32;
	localparam int byte_count = data_width / 8;

	// Frame geometry counted in output beats
	localparam int row_beats   = 4;
	localparam int frame_rows  = 4;
	localparam int frame_beats = row_beats * frame_rows;

	// Depth stays a power of two so the pointers wrap on their own
	localparam int fifo_depth     = 8;
	localparam int fifo_ptr_width = $clog2(fifo_depth);
	localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

	// Holds every count from zero up to frame_beats
	localparam int beat_cnt_width = $clog2(frame_beats + 1);

	typedef logic [data_width-1:0] data_t;

	// Control register as seen by the host
	typedef struct packed {
		logic upend;
		logic upstart;
	} ctrl_word_t;

	// One write-back into the control register
	typedef struct packed {
		logic       wrt;
		ctrl_word_t data;
	} crf_wr_t;

	// One beat on the output stream
	typedef struct packed {
		logic  tvalid;
		data_t tdata;
		logic  tlast;
	} axis_t;

endpackage

// File: rtl/upsp_ac_ctrl.sv
`timescale 1ns/1ps

module upsp_ac_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  upsp_ac_pkg::ctrl_word_t ctrl,
	input  logic                    frame_done,
	output upsp_ac_pkg::crf_wr_t    crf_wr,
	output logic                    processing,
	output logic                    time_window
);

	logic start_req;
	logic end_ack;
	logic frame_close;
	logic end_req;

	// Host asks for a new frame while the block is idle
	assign start_req = ctrl.upstart & ~ctrl.upend & ~processing;

	// Host has seen the end bit and left start clear
	assign end_ack = ~ctrl.upstart & ctrl.upend & processing;

	// Final beat of the frame left on the stream
	assign frame_close = frame_done & processing & ctrl.upstart;

	// Start bit is cleared so the end bit goes out once
	assign end_req = processing & ~ctrl.upstart & ~ctrl.upend & ~crf_wr.wrt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processing <= 1'b0;
		end else if (start_req) begin
			processing <= 1'b1;
		end else if (end_ack) begin
			processing <= 1'b0;
		end
	end

	// Up-sampler may only write while this is open
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_window <= 1'b0;
		end else if (start_req) begin
			time_window <= 1'b1;
		end else if (frame_close) begin
			time_window <= 1'b0;
		end
	end

	// First clear upstart, then raise upend on a later cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crf_wr <= '0;
		end else if (frame_close) begin
			crf_wr.wrt          <= 1'b1;
			crf_wr.data.upend   <= 1'b0;
			crf_wr.data.upstart <= 1'b0;
		end else if (end_req) begin
			crf_wr.wrt          <= 1'b1;
			crf_wr.data.upend   <= 1'b1;
			crf_wr.data.upstart <= 1'b0;
		end else begin
			crf_wr.wrt <= 1'b0;
		end
	end

endmodule

// File: rtl/upsp_ac_outbuf.sv
`timescale 1ns/1ps

module upsp_ac_outbuf (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  upsp_ac_pkg::data_t in_data,
	output logic               in_ready,
	input  logic               time_window,
	input  logic               pop,
	input  logic               frame_done,
	output upsp_ac_pkg::data_t buf_rdata,
	output logic               buf_empty
);

	import upsp_ac_pkg::*;

	data_t                     mem [fifo_depth];
	logic [fifo_ptr_width-1:0] wr_ptr;
	logic [fifo_ptr_width-1:0] rd_ptr;
	logic [fifo_cnt_width-1:0] count;
	logic                      full;
	logic                      push;

	assign full      = (count == fifo_cnt_width'(fifo_depth));
	assign buf_empty = (count == '0);

	// Writes only land inside the operating window
	assign in_ready = ~full & time_window;
	assign push     = in_valid & in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (frame_done) begin
			// Leftovers of the finished frame are dropped
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// Registered read port, word stays put until the next pop
	always_ff @(posedge clk) begin
		if (pop) begin
			buf_rdata <= mem[rd_ptr];
		end
	end

endmodule

// File: rtl/upsp_ac_stream_out.sv
`timescale 1ns/1ps

module upsp_ac_stream_out (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               time_window,
	input  logic               buf_empty,
	input  upsp_ac_pkg::data_t buf_rdata,
	output logic               pop,
	output upsp_ac_pkg::axis_t m_axis,
	input  logic               m_tready,
	output logic               frame_done
);

	import upsp_ac_pkg::*;

	logic [beat_cnt_width-1:0] beat_cnt;
	logic [beat_cnt_width-1:0] beat_next;
	logic                      frame_full;
	logic                      row_end;
	logic                      tvalid_q;
	logic                      tlast_q;
	data_t                     tdata_swap;

	assign beat_next  = beat_cnt + 1'b1;
	assign frame_full = (beat_cnt == beat_cnt_width'(frame_beats));

	// Beat being popped closes a row
	assign row_end = ((beat_next % row_beats) == 0);

	// Pop when the output slot is free or is being emptied this cycle
	assign pop = ~buf_empty & time_window & ~frame_full & (~tvalid_q | m_tready);

	// Last beat of the frame accepted by the sink
	assign frame_done = tvalid_q & m_tready & tlast_q & frame_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (frame_done) begin
			beat_cnt <= '0;
		end else if (pop) begin
			beat_cnt <= beat_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tvalid_q <= 1'b0;
			tlast_q  <= 1'b0;
		end else if (pop) begin
			tvalid_q <= 1'b1;
			tlast_q  <= row_end;
		end else if (m_tready) begin
			tvalid_q <= 1'b0;
			tlast_q  <= 1'b0;
		end
	end

	// Sink expects the bytes in the opposite order
	always_comb begin
		for (int i = 0; i < byte_count; i++) begin
			tdata_swap[i*8 +: 8] = buf_rdata[(byte_count-1-i)*8 +: 8];
		end
	end

	assign m_axis = '{tvalid: tvalid_q, tdata: tdata_swap, tlast: tlast_q};

endmodule

// File: rtl/upsp_ac_top.sv
`timescale 1ns/1ps

module upsp_ac_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  upsp_ac_pkg::ctrl_word_t ctrl,
	output upsp_ac_pkg::crf_wr_t    crf_wr,
	output logic                    processing,
	input  logic                    in_valid,
	input  upsp_ac_pkg::data_t      in_data,
	output logic                    in_ready,
	output upsp_ac_pkg::axis_t      m_axis,
	input  logic                    m_tready
);

	import upsp_ac_pkg::*;

	logic  time_window;
	logic  pop;
	logic  frame_done;
	logic  buf_empty;
	data_t buf_rdata;

	upsp_ac_ctrl upsp_ac_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ctrl        (ctrl),
		.frame_done  (frame_done),
		.crf_wr      (crf_wr),
		.processing  (processing),
		.time_window (time_window)
	);

	upsp_ac_outbuf upsp_ac_outbuf_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_ready    (in_ready),
		.time_window (time_window),
		.pop         (pop),
		.frame_done  (frame_done),
		.buf_rdata   (buf_rdata),
		.buf_empty   (buf_empty)
	);

	upsp_ac_stream_out upsp_ac_stream_out_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.time_window (time_window),
		.buf_empty   (buf_empty),
		.buf_rdata   (buf_rdata),
		.pop         (pop),
		.m_axis      (m_axis),
		.m_tready    (m_tready),
		.frame_done  (frame_done)
	);

endmodule

// File: dv/upsp_ac_checker.sv
`timescale 1ns/1ps

module upsp_ac_checker (
	input  logic                    clk,
	input  logic                    rst_n,
	input  upsp_ac_pkg::ctrl_word_t ctrl,
	input  upsp_ac_pkg::crf_wr_t    crf_wr,
	input  logic                    processing,
	input  logic                    in_valid,
	input  upsp_ac_pkg::data_t      in_data,
	input  logic                    in_ready,
	input  upsp_ac_pkg::axis_t      m_axis,
	input  logic                    m_tready,
	output int                      tests_done,
	output int                      check_count,
	output int                      error_count
);

	import upsp_ac_pkg::*;

	data_t expected_q [$];
	data_t word;
	int    beat_num        = 0;
	int    wb_num          = 0;
	int    frame_num       = 0;
	int    test_errors     = 0;
	int    reset_edges     = 0;
	logic  reset_applied   = 1'b0;
	logic  frame_ended     = 1'b0;
	logic  exp_processing  = 1'b0;
	logic  prev_processing = 1'b0;
	logic  held_beat       = 1'b0;
	axis_t prev_axis       = '0;

	initial begin
		tests_done  = 0;
		check_count = 0;
		error_count = 0;
	end

	// Lowest input byte ends up in the top byte of the result
	function automatic data_t reverse_bytes(data_t w);
		data_t r;
		r = '0;
		for (int i = 0; i < byte_count; i++)
			r = (r << 8) | data_t'(w[8*i +: 8]);
		return r;
	endfunction

	task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic report_problem(string what);
		error_count++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic close_test(string name);
		tests_done++;
		$display("test %0d %s finished with %0d errors", tests_done, name,
			error_count - test_errors);
		test_errors = error_count;
	endtask

	// All values are sampled before the edge updates them
	always @(posedge clk) begin
		if (!rst_n || reset_edges < 2) begin
			// The first edge in reset is the one that clears the flops
			if (reset_applied) begin
				compare_value("m_axis.tvalid", 1'b0, m_axis.tvalid);
				compare_value("in_ready", 1'b0, in_ready);
				compare_value("processing", 1'b0, processing);
				compare_value("crf_wr.wrt", 1'b0, crf_wr.wrt);
			end
			reset_applied = 1'b1;
			if (rst_n) begin
				reset_edges++;
				if (reset_edges == 2)
					close_test("reset");
			end
		end
		if (rst_n) begin
			// Start and end conditions take effect one edge later
			compare_value("processing", exp_processing, processing);
			if (ctrl.upstart && !ctrl.upend && !exp_processing)
				exp_processing = 1'b1;
			else if (!ctrl.upstart && ctrl.upend && exp_processing)
				exp_processing = 1'b0;

			if (!processing && in_ready)
				report_problem("in_ready is high while processing is low");
			if (in_valid && in_ready)
				expected_q.push_back(in_data);

			if (held_beat) begin
				compare_value("m_axis.tvalid", 1'b1, m_axis.tvalid);
				compare_value("m_axis.tdata", prev_axis.tdata, m_axis.tdata);
				compare_value("m_axis.tlast", prev_axis.tlast, m_axis.tlast);
			end
			held_beat = m_axis.tvalid && !m_tready;
			prev_axis = m_axis;

			if (m_axis.tvalid && m_tready) begin
				if (frame_ended) begin
					report_problem("a beat was sent after the last beat of the frame");
				end else if (expected_q.size() == 0) begin
					report_problem("a beat was sent with no accepted input word left");
				end else begin
					word = expected_q.pop_front();
					beat_num++;
					compare_value("m_axis.tdata", reverse_bytes(word), m_axis.tdata);
					compare_value("m_axis.tlast", (beat_num % row_beats) == 0, m_axis.tlast);
					// Words accepted beyond the frame are flushed by the buffer
					if (beat_num == frame_beats) begin
						frame_ended = 1'b1;
						expected_q.delete();
					end
				end
			end

			if (crf_wr.wrt) begin
				if (!frame_ended)
					report_problem("control write-back before the end of the frame");
				else if (wb_num == 0)
					compare_value("crf_wr.data", ctrl_word_t'{upend: 1'b0, upstart: 1'b0},
						crf_wr.data);
				else if (wb_num == 1)
					compare_value("crf_wr.data", ctrl_word_t'{upend: 1'b1, upstart: 1'b0},
						crf_wr.data);
				else
					report_problem("more than two control write-backs in one frame");
				wb_num++;
			end

			if (prev_processing && !processing) begin
				frame_num++;
				if (beat_num != frame_beats)
					report_problem("processing ended before all beats of the frame were sent");
				if (wb_num != 2)
					report_problem("processing ended without both control write-backs");
				close_test($sformatf("frame %0d", frame_num));
				beat_num    = 0;
				wb_num      = 0;
				frame_ended = 1'b0;
			end
			prev_processing = processing;
		end
	end

endmodule

// File: dv/upsp_ac_tb.sv
`timescale 1ns/1ps

module upsp_ac_tb;

	import upsp_ac_pkg::*;

	localparam int num_frames      = 3;
	localparam int reset_cycles    = 5;
	localparam int watchdog_cycles = reset_cycles + num_frames * frame_beats * 40;

	logic       clk;
	logic       rst_n          = 1'b0;
	ctrl_word_t ctrl           = '0;
	crf_wr_t    crf_wr;
	logic       processing;
	logic       in_valid       = 1'b0;
	data_t      in_data        = '0;
	logic       in_ready;
	axis_t      m_axis;
	logic       m_tready       = 1'b0;
	integer     seed           = 32'h2116_20bc;
	logic [2:0] ack_wait       = '0;
	int         frames_started = 0;
	int         tests_done;
	int         check_count;
	int         error_count;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

	// Up-sampler words and sink readiness, about 70% ready
	always @(posedge clk) begin
		if (!rst_n) begin
			in_valid <= 1'b0;
			in_data  <= '0;
			m_tready <= 1'b0;
		end else begin
			in_valid <= ({$random(seed)} % 2) == 1;
			in_data  <= $random(seed);
			m_tready <= ({$random(seed)} % 10) < 7;
		end
	end

	// Register file with a host that acknowledges the end bit and starts frames
	always @(posedge clk) begin
		if (!rst_n) begin
			ctrl     <= '0;
			ack_wait <= '0;
		end else if (crf_wr.wrt) begin
			ctrl <= crf_wr.data;
			if (crf_wr.data.upend)
				ack_wait <= 3'(1 + {$random(seed)} % 4);
		end else if (ack_wait != 0) begin
			if (ack_wait == 1)
				ctrl.upend <= 1'b0;
			ack_wait <= ack_wait - 1'b1;
		end else if (!ctrl.upstart && !ctrl.upend && !processing &&
				frames_started < num_frames) begin
			ctrl.upstart   <= 1'b1;
			frames_started <= frames_started + 1;
		end
	end

	upsp_ac_top upsp_ac_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.crf_wr     (crf_wr),
		.processing (processing),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.m_axis     (m_axis),
		.m_tready   (m_tready)
	);

	upsp_ac_checker upsp_ac_checker_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.ctrl        (ctrl),
		.crf_wr      (crf_wr),
		.processing  (processing),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_ready    (in_ready),
		.m_axis      (m_axis),
		.m_tready    (m_tready),
		.tests_done  (tests_done),
		.check_count (check_count),
		.error_count (error_count)
	);

	// Reset test plus one test per frame
	initial begin
		wait (tests_done == num_frames + 1);
		repeat (4) @(posedge clk);
		$display("tests %0d, checks %0d, errors %0d", tests_done, check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the frames did not finish within %0d cycles", watchdog_cycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: upsp_ac.f
rtl/upsp_ac_pkg.sv
rtl/upsp_ac_ctrl.sv
rtl/upsp_ac_outbuf.sv
rtl/upsp_ac_stream_out.sv
rtl/upsp_ac_top.sv
dv/upsp_ac_checker.sv
dv/upsp_ac_tb.sv

// File: Bender.yml
package:
  name: upsp_ac

sources:
  - rtl/upsp_ac_pkg.sv
  - rtl/upsp_ac_ctrl.sv
  - rtl/upsp_ac_outbuf.sv
  - rtl/upsp_ac_stream_out.sv
  - rtl/upsp_ac_top.sv
  - target: test
    files:
      - dv/upsp_ac_checker.sv
      - dv/upsp_ac_tb.sv
